/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing
LINTFLAGS = --lint-only -Wall --timing
TOP       = microcode_tb
FILELIST  = project.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^Test passed$$" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* dispatch_buffer.sv */
module dispatch_buffer #(
  parameter type payload_t = logic [7:0],
  parameter int  buf_depth = 4
) (
  input  logic     clk,
  input  logic     reset_n,
  input  logic     push_valid,
  input  payload_t push_data,
  output payload_t head,
  output logic     not_empty,
  input  logic     pop,
  output logic     credit_return
);

  localparam int ptr_w = (buf_depth > 1) ? $clog2(buf_depth) : 1;
  localparam int cnt_w = $clog2(buf_depth + 1);

  payload_t         mem [buf_depth];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [cnt_w-1:0] count;

  // Wraps for depths that are not a power of two
  function automatic logic [ptr_w-1:0] next_ptr(logic [ptr_w-1:0] ptr);
    return (ptr == ptr_w'(buf_depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign head      = mem[rd_ptr];
  assign not_empty = count != '0;

  always_ff @(posedge clk) begin
    if (push_valid) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      wr_ptr        <= '0;
      rd_ptr        <= '0;
      count         <= '0;
      credit_return <= 1'b0;
    end else begin
      if (push_valid) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      count         <= count + cnt_w'(push_valid) - cnt_w'(pop);
      // One credit back per entry that leaves
      credit_return <= pop;
    end
  end

endmodule

/* mc_pkg.sv */
package mc_pkg;

  typedef enum logic [4:0] {
    REG_A,
    REG_B,
    REG_X,
    REG_Y,
    REG_MX,
    REG_MY,
    REG_SP,
    REG_IMM,
    REG_ALU,
    REG_ALU_WITH_FLAGS,
    REG_SETPC
  } reg_sel_t;

  typedef enum logic [2:0] {
    REG_NONE,
    INC_X,
    INC_Y,
    INC_SP,
    DEC_SP
  } reg_inc_t;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_ADC,
    ALU_SUB,
    ALU_SBC,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_RRC,
    ALU_RLC
  } alu_op_t;

  typedef enum logic [1:0] {
    CYCLE_NONE,
    CYCLE_REG_FETCH,
    CYCLE_REG_WRITE
  } cycle_t;

  typedef enum logic [1:0] {
    LEN_5,
    LEN_7,
    LEN_12
  } instr_len_t;

  typedef enum logic [2:0] {
    UOP_NOP,
    UOP_TRANSFER,
    UOP_TRANSALU,
    UOP_SETPC,
    UOP_JMP
  } uop_t;

  typedef struct packed {
    logic [6:0] start_addr;
    instr_len_t len;
    logic [3:0] imm;
  } dispatch_t;

  typedef struct packed {
    reg_sel_t src;
    reg_sel_t dst;
    reg_inc_t inc;
    alu_op_t  alu;
    logic [3:0] imm;
  } bus_ctrl_t;

  // Micro-instruction layouts, all 16 bits
  typedef struct packed {
    uop_t     op;
    reg_sel_t src;
    reg_sel_t dst;
    reg_inc_t inc;
  } ui_transfer_t;

  typedef struct packed {
    uop_t     op;
    logic     rsvd;
    alu_op_t  alu;
    reg_sel_t dst;
    reg_inc_t inc;
  } ui_transalu_t;

  typedef struct packed {
    uop_t       op;
    logic       cond;
    logic       sel_carry;
    logic       flag_val;
    logic [9:0] target;
  } ui_jmp_t;

  localparam bus_ctrl_t CTRL_IDLE = '{
    src: REG_ALU,
    dst: REG_ALU,
    inc: REG_NONE,
    alu: ALU_ADD,
    imm: 4'h0
  };

  function automatic logic [3:0] len_clocks(instr_len_t len);
    case (len)
      LEN_7:   return 4'd7;
      LEN_12:  return 4'd12;
      default: return 4'd5;
    endcase
  endfunction

  function automatic logic [15:0] transfer_word(reg_sel_t src_sel, reg_sel_t dst_sel,
                                                reg_inc_t inc_sel);
    ui_transfer_t w;
    w = '{op: UOP_TRANSFER, src: src_sel, dst: dst_sel, inc: inc_sel};
    return w;
  endfunction

  function automatic logic [15:0] transalu_word(alu_op_t op_sel, reg_sel_t dst_sel,
                                                reg_inc_t inc_sel);
    ui_transalu_t w;
    w = '{op: UOP_TRANSALU, rsvd: 1'b0, alu: op_sel, dst: dst_sel, inc: inc_sel};
    return w;
  endfunction

  function automatic logic [15:0] setpc_word();
    return {UOP_SETPC, 13'h0};
  endfunction

  function automatic logic [15:0] jmp_word(logic cond, logic sel_carry, logic flag_val,
                                           logic [9:0] target);
    ui_jmp_t w;
    w = '{op: UOP_JMP, cond: cond, sel_carry: sel_carry, flag_val: flag_val, target: target};
    return w;
  endfunction

endpackage

/* microcode_rom.sv */
module microcode_rom #(
  parameter int rom_words = 1024
) (
  input  logic        clk,
  input  logic [9:0]  rom_addr,
  output logic [15:0] rom_data
);
  import mc_pkg::*;

  logic [15:0] rom [rom_words];

  function automatic logic [15:0] ucode_word(int addr);
    case (addr)
      // Class 0
      0:  return transfer_word(REG_A, REG_B, REG_NONE);
      // Class 1
      4:  return transalu_word(ALU_ADD, REG_A, INC_X);
      // Class 2
      8:  return transfer_word(REG_IMM, REG_A, REG_NONE);
      // Class 3
      12: return setpc_word();
      // Class 4, skips 17 when zero is set
      16: return jmp_word(1'b1, 1'b0, 1'b1, 10'd18);
      17: return transfer_word(REG_A, REG_X, REG_NONE);
      18: return transfer_word(REG_B, REG_Y, REG_NONE);
      // Classes 5 to 7
      20: return transfer_word(REG_X, REG_A, REG_NONE);
      21: return transalu_word(ALU_SUB, REG_B, REG_NONE);
      24: return transfer_word(REG_MX, REG_B, INC_X);
      25: return transalu_word(ALU_XOR, REG_A, INC_Y);
      28: return transfer_word(REG_MY, REG_A, REG_NONE);
      29: return transalu_word(ALU_RRC, REG_A, DEC_SP);
      default: return {UOP_NOP, 13'h0};
    endcase
  endfunction

  for (genvar i = 0; i < rom_words; i++) begin : g_word
    assign rom[i] = ucode_word(i);
  end

  always_ff @(posedge clk) begin
    rom_data <= rom[rom_addr];
  end

endmodule

/* microcode_sequencer.sv */
module microcode_sequencer (
  input  logic              clk,
  input  logic              reset_n,
  input  mc_pkg::dispatch_t head,
  input  logic              not_empty,
  output logic              pop,
  output logic [9:0]        rom_addr,
  input  logic [15:0]       rom_data,
  input  logic              zero,
  input  logic              carry,
  output mc_pkg::bus_ctrl_t ctrl,
  output mc_pkg::cycle_t    cycle,
  output logic              ctrl_valid,
  output logic              increment_pc,
  output logic              instr_done
);
  import mc_pkg::*;

  logic [3:0]   stage;
  logic [9:0]   micro_pc;
  instr_len_t   len_q;
  logic [3:0]   imm_q;
  logic         disable_inc;
  logic [3:0]   len_clk;
  logic         write_stage;
  ui_transfer_t ui_xfer;
  ui_transalu_t ui_alu;
  ui_jmp_t      ui_jmp;
  logic         jmp_flag;
  logic         jmp_taken;
  logic         emit;
  bus_ctrl_t    ctrl_next;

  assign len_clk     = len_clocks(len_q);
  assign pop         = (stage == 4'd0) && not_empty;
  assign write_stage = (stage != 4'd0) && !stage[0];

  // DECODE reads the first word of the microprogram directly
  assign rom_addr = pop ? {1'b0, head.start_addr, 2'b00} : micro_pc;

  assign increment_pc = (stage == len_clk - 4'd2) && !disable_inc;
  assign instr_done   = stage == len_clk - 4'd1;

  assign ui_xfer = ui_transfer_t'(rom_data);
  assign ui_alu  = ui_transalu_t'(rom_data);
  assign ui_jmp  = ui_jmp_t'(rom_data);

  always_comb begin
    if (stage == 4'd0) begin
      cycle = CYCLE_NONE;
    end else if (stage[0]) begin
      cycle = CYCLE_REG_FETCH;
    end else begin
      cycle = CYCLE_REG_WRITE;
    end
  end

  // Micro-op decode of the fetched word
  always_comb begin
    ctrl_next = CTRL_IDLE;
    emit      = 1'b0;
    jmp_flag  = ui_jmp.sel_carry ? carry : zero;
    jmp_taken = 1'b0;
    case (ui_xfer.op)
      UOP_TRANSFER: begin
        ctrl_next.src = ui_xfer.src;
        ctrl_next.dst = ui_xfer.dst;
        ctrl_next.inc = ui_xfer.inc;
        if (ui_xfer.src == REG_IMM) begin
          ctrl_next.imm = imm_q;
        end
        emit = 1'b1;
      end
      UOP_TRANSALU: begin
        ctrl_next.src = REG_ALU_WITH_FLAGS;
        ctrl_next.alu = ui_alu.alu;
        ctrl_next.dst = ui_alu.dst;
        ctrl_next.inc = ui_alu.inc;
        emit          = 1'b1;
      end
      UOP_SETPC: begin
        ctrl_next.dst = REG_SETPC;
        emit          = 1'b1;
      end
      UOP_JMP: begin
        jmp_taken = !ui_jmp.cond || (ui_jmp.flag_val == jmp_flag);
      end
      default: begin
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      stage       <= 4'd0;
      micro_pc    <= 10'd0;
      len_q       <= LEN_5;
      disable_inc <= 1'b0;
      ctrl        <= CTRL_IDLE;
      ctrl_valid  <= 1'b0;
    end else begin
      ctrl_valid <= 1'b0;

      if (stage == 4'd0) begin
        // Wait here until an entry is queued
        if (not_empty) begin
          stage       <= 4'd1;
          micro_pc    <= {1'b0, head.start_addr, 2'b00};
          len_q       <= head.len;
          disable_inc <= 1'b0;
        end
      end else if (instr_done) begin
        stage <= 4'd0;
      end else begin
        stage <= stage + 4'd1;
      end

      if (write_stage) begin
        ctrl_valid <= emit;
        if (emit) begin
          ctrl <= ctrl_next;
        end
        if (ui_xfer.op == UOP_SETPC) begin
          disable_inc <= 1'b1;
        end
        micro_pc <= jmp_taken ? ui_jmp.target : micro_pc + 10'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      imm_q <= head.imm;
    end
  end

endmodule

/* microcode_tb.sv */
module microcode_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import mc_pkg::*;

  localparam int buf_depth    = 4;
  localparam int period_ns    = 100;
  localparam int reset_cycles = 10;
  localparam int max_len      = 12;
  localparam int burst_len    = 12;
  localparam int total_instrs = (buf_depth + 2) + 9 + 2 + 5 + burst_len;
  // Every instruction at the longest length, four times over
  localparam int watchdog_ns  = (reset_cycles + total_instrs * max_len) * 4 * period_ns;

  logic        clk;
  logic        reset_n;
  logic [11:0] instr;
  logic        instr_valid;
  logic        instr_ready;
  logic        zero;
  logic        carry;
  bus_ctrl_t   ctrl;
  cycle_t      cycle;
  logic        ctrl_valid;
  logic        increment_pc;
  logic        instr_done;

  // Observed activity
  bus_ctrl_t   ctrl_log[$];
  cycle_t      done_cycle_log[$];
  int          done_time_log[$];
  int          inc_count = 0;
  int          done_count = 0;
  int          clk_count = 0;

  // Reference model results
  bus_ctrl_t   exp_ctrl[$];
  cycle_t      exp_done_cycle[$];
  int          exp_len[$];
  int          exp_inc = 0;

  logic [31:0] lcg_state = 32'hb99d;
  int          errors = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          stalls = 0;

  tb_clock_gen #(
    .period_ns   (period_ns),
    .reset_cycles(reset_cycles)
  ) clock_gen (
    .clk    (clk),
    .reset_n(reset_n)
  );

  microcode_top #(
    .buf_depth(buf_depth)
  ) DUT (
    .clk         (clk),
    .reset_n     (reset_n),
    .instr       (instr),
    .instr_valid (instr_valid),
    .instr_ready (instr_ready),
    .zero        (zero),
    .carry       (carry),
    .ctrl        (ctrl),
    .cycle       (cycle),
    .ctrl_valid  (ctrl_valid),
    .increment_pc(increment_pc),
    .instr_done  (instr_done)
  );

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic logic [3:0] next_nibble();
    logic [31:0] r;
    r = next_random();
    return r[19:16];
  endfunction

  // One opcode nibble that falls into each class
  function automatic logic [3:0] class_opcode(int cls);
    case (cls)
      0:       return 4'h0;
      1:       return 4'h2;
      2:       return 4'h3;
      3:       return 4'h5;
      4:       return 4'h6;
      5:       return 4'h8;
      6:       return 4'hb;
      default: return 4'hd;
    endcase
  endfunction

  function automatic int class_clocks(int cls);
    case (cls)
      2, 4, 6: return 7;
      7:       return 12;
      default: return 5;
    endcase
  endfunction

  function automatic bus_ctrl_t make_ctrl(reg_sel_t src, reg_sel_t dst, reg_inc_t inc,
                                          alu_op_t alu, logic [3:0] imm);
    bus_ctrl_t c;
    c.src = src;
    c.dst = dst;
    c.inc = inc;
    c.alu = alu;
    c.imm = imm;
    return c;
  endfunction

  // Expected bus words, pulses and final phase of one instruction
  task automatic add_expected(input int cls, input logic [3:0] imm, input logic zero_val);
    case (cls)
      0: exp_ctrl.push_back(make_ctrl(REG_A, REG_B, REG_NONE, ALU_ADD, 4'h0));
      1: exp_ctrl.push_back(make_ctrl(REG_ALU_WITH_FLAGS, REG_A, INC_X, ALU_ADD, 4'h0));
      2: exp_ctrl.push_back(make_ctrl(REG_IMM, REG_A, REG_NONE, ALU_ADD, imm));
      3: exp_ctrl.push_back(make_ctrl(REG_ALU, REG_SETPC, REG_NONE, ALU_ADD, 4'h0));
      4: begin
        if (!zero_val) begin
          exp_ctrl.push_back(make_ctrl(REG_A, REG_X, REG_NONE, ALU_ADD, 4'h0));
        end
        exp_ctrl.push_back(make_ctrl(REG_B, REG_Y, REG_NONE, ALU_ADD, 4'h0));
      end
      5: begin
        exp_ctrl.push_back(make_ctrl(REG_X, REG_A, REG_NONE, ALU_ADD, 4'h0));
        exp_ctrl.push_back(make_ctrl(REG_ALU_WITH_FLAGS, REG_B, REG_NONE, ALU_SUB, 4'h0));
      end
      6: begin
        exp_ctrl.push_back(make_ctrl(REG_MX, REG_B, INC_X, ALU_ADD, 4'h0));
        exp_ctrl.push_back(make_ctrl(REG_ALU_WITH_FLAGS, REG_A, INC_Y, ALU_XOR, 4'h0));
      end
      default: begin
        exp_ctrl.push_back(make_ctrl(REG_MY, REG_A, REG_NONE, ALU_ADD, 4'h0));
        exp_ctrl.push_back(make_ctrl(REG_ALU_WITH_FLAGS, REG_A, DEC_SP, ALU_RRC, 4'h0));
      end
    endcase
    if (cls != 3) begin
      exp_inc++;
    end
    exp_len.push_back(class_clocks(cls));
    // Last stage is L-1, odd stages fetch
    if ((class_clocks(cls) - 1) % 2 == 1) begin
      exp_done_cycle.push_back(CYCLE_REG_FETCH);
    end else begin
      exp_done_cycle.push_back(CYCLE_REG_WRITE);
    end
  endtask

  always @(negedge clk) begin
    if (reset_n) begin
      clk_count = clk_count + 1;
      if (ctrl_valid) begin
        ctrl_log.push_back(ctrl);
      end
      if (increment_pc) begin
        inc_count = inc_count + 1;
      end
      if (instr_done) begin
        done_count = done_count + 1;
        done_time_log.push_back(clk_count);
        done_cycle_log.push_back(cycle);
      end
    end
  end

  task automatic clear_logs();
    ctrl_log.delete();
    done_cycle_log.delete();
    done_time_log.delete();
    exp_ctrl.delete();
    exp_done_cycle.delete();
    exp_len.delete();
    inc_count  = 0;
    done_count = 0;
    exp_inc    = 0;
  endtask

  // Called on a falling edge, returns on the falling edge after acceptance
  task automatic send_instr(input int cls, input logic [3:0] imm);
    logic [31:0] r;
    r = next_random();
    instr       = {class_opcode(cls), r[23:20], imm};
    instr_valid = 1'b1;
    while (!instr_ready) begin
      stalls++;
      @(negedge clk);
    end
    @(negedge clk);
    instr_valid = 1'b0;
    add_expected(cls, imm, zero);
  endtask

  task automatic wait_done(input int n);
    int waited;
    waited = 0;
    do begin
      @(posedge clk);
      waited++;
    end while (done_count < n && waited < n * max_len * 3 + 20);
    if (done_count < n) begin
      $display("Timed out waiting for %0d finished instructions, only %0d finished",
               n, done_count);
      errors++;
    end
    // Let the last registered ctrl word reach the log
    repeat (2) @(posedge clk);
    @(negedge clk);
  endtask

  task automatic check_ctrl(input string name, input bus_ctrl_t got, input bus_ctrl_t exp);
    if (got !== exp) begin
      $display("[ERROR] %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_cycle(input string name, input cycle_t got, input cycle_t exp);
    if (got !== exp) begin
      $display("[ERROR] %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("[ERROR] %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_logs();
    check_count("ctrl_valid words", ctrl_log.size(), exp_ctrl.size());
    for (int i = 0; i < exp_ctrl.size() && i < ctrl_log.size(); i++) begin
      check_ctrl($sformatf("ctrl[%0d]", i), ctrl_log[i], exp_ctrl[i]);
    end
    check_count("increment_pc pulses", inc_count, exp_inc);
    check_count("instr_done pulses", done_count, exp_len.size());
    for (int i = 0; i < exp_done_cycle.size() && i < done_cycle_log.size(); i++) begin
      check_cycle($sformatf("cycle at instr_done[%0d]", i), done_cycle_log[i],
                  exp_done_cycle[i]);
    end
    check_cycle("cycle when idle", cycle, CYCLE_NONE);
  endtask

  task automatic finish_test(input string name, input int err_before);
    tests_run++;
    if (errors == err_before) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: FAILED with %0d errors", name, errors - err_before);
    end
  endtask

  task automatic test_reset_credits();
    int err0;
    err0 = errors;
    check_ctrl("ctrl", ctrl, CTRL_IDLE);
    check_cycle("cycle", cycle, CYCLE_NONE);
    check_count("ctrl_valid", int'(ctrl_valid), 0);
    check_count("increment_pc", int'(increment_pc), 0);
    check_count("instr_done", int'(instr_done), 0);
    check_count("instr_ready", int'(instr_ready), 1);
    clear_logs();
    stalls = 0;
    for (int i = 0; i < buf_depth; i++) begin
      send_instr(7, next_nibble());
    end
    check_count("stalls within buf_depth", stalls, 0);
    for (int i = 0; i < 2; i++) begin
      send_instr(7, next_nibble());
    end
    if (stalls == 0) begin
      $display("instr_ready never dropped although the buffer was full");
      errors++;
    end
    wait_done(buf_depth + 2);
    check_logs();
    finish_test("reset_and_credits", err0);
  endtask

  task automatic test_classes();
    int err0;
    err0 = errors;
    clear_logs();
    zero = 1'b0;
    for (int cls = 0; cls < 8; cls++) begin
      send_instr(cls, next_nibble());
    end
    send_instr(2, 4'h9);
    wait_done(9);
    check_logs();
    finish_test("all_classes", err0);
  endtask

  task automatic test_jump();
    int err0;
    err0 = errors;
    clear_logs();
    zero = 1'b1;
    send_instr(4, next_nibble());
    wait_done(1);
    zero = 1'b0;
    send_instr(4, next_nibble());
    wait_done(2);
    check_logs();
    finish_test("conditional_jump", err0);
  endtask

  task automatic test_pulses();
    int err0;
    err0 = errors;
    clear_logs();
    send_instr(3, next_nibble());
    send_instr(3, next_nibble());
    send_instr(0, next_nibble());
    send_instr(3, next_nibble());
    send_instr(1, next_nibble());
    wait_done(5);
    check_logs();
    check_count("increment_pc pulses with three SETPC", inc_count, 2);
    finish_test("pc_pulses", err0);
  endtask

  task automatic test_burst();
    int          err0;
    logic [31:0] r;
    err0 = errors;
    clear_logs();
    r     = next_random();
    zero  = r[16];
    carry = r[17];
    for (int i = 0; i < burst_len; i++) begin
      r = next_random();
      send_instr(int'(r[18:16]), r[27:24]);
    end
    wait_done(burst_len);
    check_logs();
    for (int i = 1; i < done_time_log.size() && i < exp_len.size(); i++) begin
      check_count($sformatf("instr_done spacing[%0d]", i),
                  done_time_log[i] - done_time_log[i - 1], exp_len[i]);
    end
    finish_test("random_burst", err0);
  endtask

  initial begin
    instr       = 12'h000;
    instr_valid = 1'b0;
    zero        = 1'b0;
    carry       = 1'b0;
    wait (reset_n === 1'b1);
    @(negedge clk);
    test_reset_credits();
    test_classes();
    test_jump();
    test_pulses();
    test_burst();
    $display("tests run %0d, failing tests %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  initial begin
    #(watchdog_ns);
    $display("Watchdog expired before the tests finished");
    $display("Test failed");
    $finish;
  end

endmodule

/* microcode_top.sv */
module microcode_top #(
  parameter int buf_depth = 4
) (
  input  logic              clk,
  input  logic              reset_n,
  input  logic [11:0]       instr,
  input  logic              instr_valid,
  output logic              instr_ready,
  input  logic              zero,
  input  logic              carry,
  output mc_pkg::bus_ctrl_t ctrl,
  output mc_pkg::cycle_t    cycle,
  output logic              ctrl_valid,
  output logic              increment_pc,
  output logic              instr_done
);
  import mc_pkg::*;

  logic        push_valid;
  dispatch_t   push_data;
  logic        credit_return;
  dispatch_t   head;
  logic        not_empty;
  logic        pop;
  logic [9:0]  rom_addr;
  logic [15:0] rom_data;

  opcode_decoder #(
    .buf_depth(buf_depth)
  ) u_decoder (
    .clk          (clk),
    .reset_n      (reset_n),
    .instr        (instr),
    .instr_valid  (instr_valid),
    .instr_ready  (instr_ready),
    .push_valid   (push_valid),
    .push_data    (push_data),
    .credit_return(credit_return)
  );

  dispatch_buffer #(
    .payload_t(dispatch_t),
    .buf_depth(buf_depth)
  ) u_buffer (
    .clk          (clk),
    .reset_n      (reset_n),
    .push_valid   (push_valid),
    .push_data    (push_data),
    .head         (head),
    .not_empty    (not_empty),
    .pop          (pop),
    .credit_return(credit_return)
  );

  microcode_sequencer u_sequencer (
    .clk         (clk),
    .reset_n     (reset_n),
    .head        (head),
    .not_empty   (not_empty),
    .pop         (pop),
    .rom_addr    (rom_addr),
    .rom_data    (rom_data),
    .zero        (zero),
    .carry       (carry),
    .ctrl        (ctrl),
    .cycle       (cycle),
    .ctrl_valid  (ctrl_valid),
    .increment_pc(increment_pc),
    .instr_done  (instr_done)
  );

  microcode_rom u_rom (
    .clk     (clk),
    .rom_addr(rom_addr),
    .rom_data(rom_data)
  );

endmodule

/* opcode_decoder.sv */
module opcode_decoder #(
  parameter int buf_depth = 4
) (
  input  logic              clk,
  input  logic              reset_n,
  input  logic [11:0]       instr,
  input  logic              instr_valid,
  output logic              instr_ready,
  output logic              push_valid,
  output mc_pkg::dispatch_t push_data,
  input  logic              credit_return
);
  import mc_pkg::*;

  localparam int credit_w = $clog2(buf_depth + 1);

  logic [credit_w-1:0] credits;
  logic                accept;
  logic [2:0]          op_class;
  dispatch_t           entry;

  // Opcode nibble to instruction class
  function automatic logic [2:0] classify(logic [3:0] opcode);
    case (opcode)
      4'h0, 4'h1:       return 3'd0;
      4'h2:             return 3'd1;
      4'h3, 4'h4:       return 3'd2;
      4'h5:             return 3'd3;
      4'h6, 4'h7:       return 3'd4;
      4'h8, 4'h9, 4'ha: return 3'd5;
      4'hb, 4'hc:       return 3'd6;
      default:          return 3'd7;
    endcase
  endfunction

  function automatic instr_len_t class_len(logic [2:0] cls);
    case (cls)
      3'd2, 3'd4, 3'd6: return LEN_7;
      3'd7:             return LEN_12;
      default:          return LEN_5;
    endcase
  endfunction

  assign instr_ready = credits != '0;
  assign accept      = instr_valid && instr_ready;
  assign op_class    = classify(instr[11:8]);

  // Each class owns four ROM words
  always_comb begin
    entry.start_addr = {4'b0000, op_class};
    entry.len        = class_len(op_class);
    entry.imm        = instr[3:0];
  end

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      credits    <= credit_w'(buf_depth);
      push_valid <= 1'b0;
    end else begin
      credits    <= credits - credit_w'(accept) + credit_w'(credit_return);
      push_valid <= accept;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      push_data <= entry;
    end
  end

endmodule

/* project.f */
mc_pkg.sv
opcode_decoder.sv
dispatch_buffer.sv
microcode_rom.sv
microcode_sequencer.sv
microcode_top.sv
tb_clock_gen.sv
microcode_tb.sv

/* tb_clock_gen.sv */
module tb_clock_gen #(
  parameter int period_ns    = 100,
  parameter int reset_cycles = 10
) (
  output logic clk,
  output logic reset_n
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk = 1'b0;
    forever #(period_ns / 2) clk = ~clk;
  end

  // Release on a falling edge, like the rest of the stimulus
  initial begin
    reset_n = 1'b0;
    repeat (reset_cycles) @(negedge clk);
    reset_n = 1'b1;
  end

endmodule
